// ==== sources.f ====
common/core_pkg.sv
hdl/pc_controller.sv
hdl/if_stage.sv
decode/reg_file.sv
decode/id_stage.sv
hdl/branch_unit.sv
hdl/hazard_ctrl.sv
hdl/fetch_top.sv
verif/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - common/core_pkg.sv
  - hdl/pc_controller.sv
  - hdl/if_stage.sv
  - decode/reg_file.sv
  - decode/id_stage.sv
  - hdl/branch_unit.sv
  - hdl/hazard_ctrl.sv
  - hdl/fetch_top.sv
  - target: simulation
    files:
      - verif/tb_fetch_top.sv

// ==== verif/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top import core_pkg::*; ();

    ////////////////////////////////////////
    // Setup
    ////////////////////////////////////////

    localparam int MEM_WORDS = 64;
    localparam int RETIRE_TIMEOUT = 200;
    localparam int N_PRELOAD = 6;
    localparam int N_EXPECT = 21;

    logic                 clk_i = 1'b0;
    logic                 rst_n_i = 1'b0;
    logic [XLEN-1:0]      imem_addr_o;
    logic [ILEN-1:0]      imem_rdata_i;
    logic                 backend_stall_i = 1'b1;
    logic                 rf_we_i = 1'b0;
    logic [RF_ADDR_W-1:0] rf_waddr_i = '0;
    logic [XLEN-1:0]      rf_wdata_i = '0;
    logic                 ex_valid_o;
    logic [XLEN-1:0]      ex_pc_o;
    logic [ILEN-1:0]      ex_instr_o;

    // Stall source mode flags
    logic   freeze = 1'b1;
    logic   random_stall = 1'b0;
    integer seed = 32'h595f2a5a;
    integer rnd;

    int mismatch_count = 0;
    int timeout_count = 0;

    // Word addressed instruction memory
    logic [ILEN-1:0] mem [MEM_WORDS];

    // Register preload ending in a write to x0 that must be dropped
    logic [RF_ADDR_W-1:0] pre_addr [N_PRELOAD] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd0};
    logic [XLEN-1:0]      pre_data [N_PRELOAD] = '{32'd5, 32'd5, 32'hffff_ffff, 32'd1,
                                                   32'h0000_0080, 32'hdead_beef};

    // Retired PCs in control flow order
    // Bubbles and wrong path words never show up
    logic [XLEN-1:0] exp_pc [N_EXPECT] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h18, 32'h20, 32'h24,
        32'h2c, 32'h30, 32'h38, 32'h3c, 32'h44, 32'h48, 32'h50,
        32'h58, 32'h5c, 32'h60, 32'h68, 32'h80, 32'h84, 32'h88
    };

    always #50 clk_i = ~clk_i;

    // Backend back pressure
    always @(posedge clk_i) begin
        if (freeze) begin
            backend_stall_i <= 1'b1;
        end else if (random_stall) begin
            rnd = $random(seed);
            backend_stall_i <= rnd[0];
        end else begin
            backend_stall_i <= 1'b0;
        end
    end

    // Combinational memory with fill words outside the array
    assign imem_rdata_i = (imem_addr_o[XLEN-1:8] == '0) ? mem[imem_addr_o[7:2]]
                                                        : fill_word(imem_addr_o);

    fetch_top dut_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .imem_addr_o     (imem_addr_o),
        .imem_rdata_i    (imem_rdata_i),
        .backend_stall_i (backend_stall_i),
        .rf_we_i         (rf_we_i),
        .rf_waddr_i      (rf_waddr_i),
        .rf_wdata_i      (rf_wdata_i),
        .ex_valid_o      (ex_valid_o),
        .ex_pc_o         (ex_pc_o),
        .ex_instr_o      (ex_instr_o)
    );

    ////////////////////////////////////////
    // Encoders
    ////////////////////////////////////////

    // ADDI to x0 with a tag folded from the whole address
    function automatic logic [ILEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        logic [11:0] tag;
        tag = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
        return {tag, 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic logic [ILEN-1:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // J type offset scramble
    function automatic logic [ILEN-1:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [ILEN-1:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    // B type offset scramble
    function automatic logic [ILEN-1:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                   input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    task automatic place(input logic [XLEN-1:0] addr, input logic [ILEN-1:0] word);
        mem[addr[7:2]] = word;
    endtask

    ////////////////////////////////////////
    // Program
    ////////////////////////////////////////

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(XLEN'(i) << 2);
        end
        // Straight line
        place(32'h00, addi_word(0, 0, 0));
        place(32'h04, addi_word(8, 0, 1));
        place(32'h08, addi_word(9, 0, 2));
        // JAL over 0x10 and 0x14
        place(32'h0c, jal_word(0, 21'd12));
        place(32'h10, addi_word(10, 0, 16));
        // Every branch kind taken once and not taken once
        place(32'h18, branch_word(F3_BEQ, 1, 2, 13'd8));
        place(32'h20, branch_word(F3_BNE, 1, 2, 13'd8));
        place(32'h24, branch_word(F3_BLT, 3, 4, 13'd8));
        place(32'h2c, branch_word(F3_BLTU, 3, 4, 13'd8));
        place(32'h30, branch_word(F3_BGE, 4, 3, 13'd8));
        place(32'h38, branch_word(F3_BGEU, 4, 3, 13'd8));
        place(32'h3c, branch_word(F3_BNE, 1, 4, 13'd8));
        place(32'h44, branch_word(F3_BLT, 4, 3, 13'd8));
        place(32'h48, branch_word(F3_BLTU, 4, 3, 13'd8));
        place(32'h50, branch_word(F3_BGEU, 3, 4, 13'd8));
        place(32'h58, branch_word(F3_BGE, 3, 4, 13'd8));
        place(32'h5c, branch_word(F3_BEQ, 1, 4, 13'd8));
        // x0 still reads zero after the write and x7 is never written
        place(32'h60, branch_word(F3_BEQ, 0, 7, 13'd8));
        // 0x80 + 1 with bit 0 cleared
        place(32'h68, jalr_word(0, 5, 12'd1));
        place(32'h80, addi_word(11, 0, 3));
        place(32'h84, addi_word(12, 0, 4));
        place(32'h88, addi_word(13, 0, 5));
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s pc %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_instr(input logic [ILEN-1:0] got, input logic [ILEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s instr %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s valid %b, expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    ////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////

    // Pipeline frozen by the stall source during and after reset
    task automatic apply_reset();
        @(posedge clk_i);
        freeze <= 1'b1;
        random_stall <= 1'b0;
        rst_n_i <= 1'b0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
    endtask

    task automatic preload_regs();
        for (int i = 0; i < N_PRELOAD; i++) begin
            @(posedge clk_i);
            rf_we_i <= 1'b1;
            rf_waddr_i <= pre_addr[i];
            rf_wdata_i <= pre_data[i];
        end
        @(posedge clk_i);
        rf_we_i <= 1'b0;
    endtask

    // Samples on negedges where outputs and stall are settled for the next edge
    task automatic walk_trace();
        logic [XLEN-1:0] held_pc;
        logic [ILEN-1:0] held_instr;
        logic            held;
        logic            accepted;
        logic            give_up;
        int              waited;
        held = 1'b0;
        give_up = 1'b0;
        for (int i = 0; i < N_EXPECT && !give_up; i++) begin
            accepted = 1'b0;
            waited = 0;
            while (!accepted && waited < RETIRE_TIMEOUT) begin
                @(negedge clk_i);
                waited++;
                // EX must not move after a stalled edge
                if (held) begin
                    check_valid(ex_valid_o, 1'b1, "held output");
                    check_pc(ex_pc_o, held_pc, "held output");
                    check_instr(ex_instr_o, held_instr, "held output");
                end
                held = ex_valid_o && backend_stall_i;
                held_pc = ex_pc_o;
                held_instr = ex_instr_o;
                accepted = ex_valid_o && !backend_stall_i;
            end
            if (!accepted) begin
                $display("timeout at %0t waiting for retired instruction %0d", $time, i);
                timeout_count++;
                give_up = 1'b1;
            end else begin
                check_pc(ex_pc_o, exp_pc[i], $sformatf("retired entry %0d", i));
                check_instr(ex_instr_o, mem[exp_pc[i][7:2]], $sformatf("retired entry %0d", i));
            end
        end
    endtask

    task automatic run_program(input logic with_stalls);
        apply_reset();
        @(negedge clk_i);
        check_valid(ex_valid_o, 1'b0, "after reset");
        check_pc(imem_addr_o, RESET_PC, "fetch after reset");
        preload_regs();
        @(posedge clk_i);
        freeze <= 1'b0;
        random_stall <= with_stalls;
        walk_trace();
    endtask

    initial begin
        load_program();
        // Free running pass followed by the same trace under random back pressure
        run_program(1'b0);
        if (timeout_count == 0) begin
            run_program(1'b1);
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count + timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Instruction memory
    output logic [XLEN-1:0]      imem_addr_o,
    input  logic [ILEN-1:0]      imem_rdata_i,

    // Backend
    input  logic                 backend_stall_i,
    input  logic                 rf_we_i,
    input  logic [RF_ADDR_W-1:0] rf_waddr_i,
    input  logic [XLEN-1:0]      rf_wdata_i,
    output logic                 ex_valid_o,
    output logic [XLEN-1:0]      ex_pc_o,
    output logic [ILEN-1:0]      ex_instr_o
);

    ////////////////////////////////////////
    // Stage wiring
    ////////////////////////////////////////

    // IF to ID
    logic [XLEN-1:0] pc_if;
    logic [ILEN-1:0] instr_if;
    logic            valid_if;

    // ID to EX
    logic [XLEN-1:0] pc_id;
    logic [ILEN-1:0] instr_id;
    logic [XLEN-1:0] imm_id;
    logic [XLEN-1:0] rs1_val_id;
    logic [XLEN-1:0] rs2_val_id;
    logic            valid_id;
    logic [XLEN-1:0] jump_target_id;
    pc_source_t      pc_source_id;

    // EX claims
    pc_source_t      pc_source_ex;
    logic            branch_decision_ex;
    logic [XLEN-1:0] branch_target_ex;
    logic [XLEN-1:0] jalr_target_ex;

    // Stall and flush
    logic stall_if;
    logic stall_id;
    logic stall_ex;
    logic flush_id;
    logic flush_ex;

    if_stage if_stage_i (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .imem_rdata_i         (imem_rdata_i),
        .imem_addr_o          (imem_addr_o),
        .pc_if_o              (pc_if),
        .instr_if_o           (instr_if),
        .valid_if_o           (valid_if),
        .stall_if_i           (stall_if),
        .flush_id_i           (flush_id),
        .valid_id_i           (valid_id),
        .valid_ex_i           (ex_valid_o),
        .jump_target_id_i     (jump_target_id),
        .branch_target_ex_i   (branch_target_ex),
        .jalr_target_ex_i     (jalr_target_ex),
        .branch_decision_ex_i (branch_decision_ex),
        .pc_source_id_i       (pc_source_id),
        .pc_source_ex_i       (pc_source_ex)
    );

    id_stage id_stage_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .pc_if_i          (pc_if),
        .instr_if_i       (instr_if),
        .valid_if_i       (valid_if),
        .stall_id_i       (stall_id),
        .flush_id_i       (flush_id),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .rf_wdata_i       (rf_wdata_i),
        .pc_id_o          (pc_id),
        .instr_id_o       (instr_id),
        .imm_id_o         (imm_id),
        .rs1_val_id_o     (rs1_val_id),
        .rs2_val_id_o     (rs2_val_id),
        .valid_id_o       (valid_id),
        .jump_target_id_o (jump_target_id),
        .pc_source_id_o   (pc_source_id)
    );

    branch_unit branch_unit_i (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .pc_id_i              (pc_id),
        .instr_id_i           (instr_id),
        .imm_id_i             (imm_id),
        .rs1_val_id_i         (rs1_val_id),
        .rs2_val_id_i         (rs2_val_id),
        .valid_id_i           (valid_id),
        .pc_source_id_i       (pc_source_id),
        .stall_ex_i           (stall_ex),
        .flush_ex_i           (flush_ex),
        .valid_ex_o           (ex_valid_o),
        .pc_source_ex_o       (pc_source_ex),
        .branch_decision_ex_o (branch_decision_ex),
        .branch_target_ex_o   (branch_target_ex),
        .jalr_target_ex_o     (jalr_target_ex),
        .ex_pc_o              (ex_pc_o),
        .ex_instr_o           (ex_instr_o)
    );

    hazard_ctrl hazard_ctrl_i (
        .valid_id_i           (valid_id),
        .valid_ex_i           (ex_valid_o),
        .branch_decision_ex_i (branch_decision_ex),
        .pc_source_id_i       (pc_source_id),
        .pc_source_ex_i       (pc_source_ex),
        .backend_stall_i      (backend_stall_i),
        .stall_if_o           (stall_if),
        .stall_id_o           (stall_id),
        .stall_ex_o           (stall_ex),
        .flush_id_o           (flush_id),
        .flush_ex_o           (flush_ex)
    );

endmodule

// ==== hdl/hazard_ctrl.sv ====
`timescale 1ns/1ps

module hazard_ctrl import core_pkg::*; (
    // Stage claims
    input  logic       valid_id_i,
    input  logic       valid_ex_i,
    input  logic       branch_decision_ex_i,
    input  pc_source_t pc_source_id_i,
    input  pc_source_t pc_source_ex_i,

    // Back pressure from backend
    input  logic       backend_stall_i,

    output logic       stall_if_o,
    output logic       stall_id_o,
    output logic       stall_ex_o,
    output logic       flush_id_o,
    output logic       flush_ex_o
);

    logic redirect_ex;
    logic redirect_id;

    // Taken branch or JALR in EX
    assign redirect_ex = valid_ex_i &&
                         (((pc_source_ex_i == PC_BRANCH) && branch_decision_ex_i) ||
                          (pc_source_ex_i == PC_JALR));
    // JAL in ID
    assign redirect_id = valid_id_i && (pc_source_id_i == PC_JAL);

    // Whole front end freezes together
    assign stall_if_o = backend_stall_i;
    assign stall_id_o = backend_stall_i;
    assign stall_ex_o = backend_stall_i;

    // Redirect stays pending while frozen and fires on the next free edge
    assign flush_id_o = (redirect_ex || redirect_id) && !backend_stall_i;
    assign flush_ex_o = redirect_ex && !backend_stall_i;

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // From ID
    input  logic [XLEN-1:0] pc_id_i,
    input  logic [ILEN-1:0] instr_id_i,
    input  logic [XLEN-1:0] imm_id_i,
    input  logic [XLEN-1:0] rs1_val_id_i,
    input  logic [XLEN-1:0] rs2_val_id_i,
    input  logic            valid_id_i,
    input  pc_source_t      pc_source_id_i,

    // Pipeline control
    input  logic            stall_ex_i,
    input  logic            flush_ex_i,

    // Redirect claim
    output logic            valid_ex_o,
    output pc_source_t      pc_source_ex_o,
    output logic            branch_decision_ex_o,
    output logic [XLEN-1:0] branch_target_ex_o,
    output logic [XLEN-1:0] jalr_target_ex_o,

    // Towards backend
    output logic [XLEN-1:0] ex_pc_o,
    output logic [ILEN-1:0] ex_instr_o
);

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    logic [XLEN-1:0] imm_ex;
    logic [XLEN-1:0] rs1_ex;
    logic [XLEN-1:0] rs2_ex;
    logic [XLEN-1:0] jalr_sum;
    logic            cond_true;

    // Control part
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_ex_o <= 1'b0;
            pc_source_ex_o <= PC_PLUS4;
        end else if (flush_ex_i) begin
            valid_ex_o <= 1'b0;
            pc_source_ex_o <= PC_PLUS4;
        end else if (!stall_ex_i) begin
            valid_ex_o <= valid_id_i;
            pc_source_ex_o <= pc_source_id_i;
        end
    end

    // Payload part
    always_ff @(posedge clk_i) begin
        if (flush_ex_i) begin
            ex_instr_o <= NOP_INSTR;
        end else if (!stall_ex_i) begin
            ex_pc_o <= pc_id_i;
            ex_instr_o <= instr_id_i;
            imm_ex <= imm_id_i;
            rs1_ex <= rs1_val_id_i;
            rs2_ex <= rs2_val_id_i;
        end
    end

    ////////////////////////////////////////
    // Resolve
    ////////////////////////////////////////

    // Branch condition by funct3
    always_comb begin
        case (ex_instr_o[14:12])
            F3_BEQ:  cond_true = (rs1_ex == rs2_ex);
            F3_BNE:  cond_true = (rs1_ex != rs2_ex);
            F3_BLT:  cond_true = ($signed(rs1_ex) < $signed(rs2_ex));
            F3_BGE:  cond_true = ($signed(rs1_ex) >= $signed(rs2_ex));
            F3_BLTU: cond_true = (rs1_ex < rs2_ex);
            F3_BGEU: cond_true = (rs1_ex >= rs2_ex);
            default: cond_true = 1'b0;
        endcase
    end

    // Only meaningful for a branch
    assign branch_decision_ex_o = (pc_source_ex_o == PC_BRANCH) && cond_true;

    // Targets
    assign branch_target_ex_o = ex_pc_o + imm_ex;
    assign jalr_sum = rs1_ex + imm_ex;
    // Bit 0 cleared for JALR
    assign jalr_target_ex_o = {jalr_sum[XLEN-1:1], 1'b0};

endmodule

// ==== decode/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // From IF
    input  logic [XLEN-1:0]      pc_if_i,
    input  logic [ILEN-1:0]      instr_if_i,
    input  logic                 valid_if_i,

    // Pipeline control
    input  logic                 stall_id_i,
    input  logic                 flush_id_i,

    // Backend write port
    input  logic                 rf_we_i,
    input  logic [RF_ADDR_W-1:0] rf_waddr_i,
    input  logic [XLEN-1:0]      rf_wdata_i,

    // Towards EX and the PC controller
    output logic [XLEN-1:0]      pc_id_o,
    output logic [ILEN-1:0]      instr_id_o,
    output logic [XLEN-1:0]      imm_id_o,
    output logic [XLEN-1:0]      rs1_val_id_o,
    output logic [XLEN-1:0]      rs2_val_id_o,
    output logic                 valid_id_o,
    output logic [XLEN-1:0]      jump_target_id_o,
    output pc_source_t           pc_source_id_o
);

    ////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////

    logic [6:0] opcode;

    // Flush drops the wrong path word, stall holds everything
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_id_o <= RESET_PC;
            instr_id_o <= NOP_INSTR;
            valid_id_o <= 1'b0;
        end else if (flush_id_i) begin
            instr_id_o <= NOP_INSTR;
            valid_id_o <= 1'b0;
        end else if (!stall_id_i) begin
            pc_id_o <= pc_if_i;
            instr_id_o <= instr_if_i;
            valid_id_o <= valid_if_i;
        end
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign opcode = instr_id_o[6:0];

    // Immediate by format, I type by default
    always_comb begin
        case (opcode)
            OPC_STORE: begin
                imm_id_o = {{20{instr_id_o[31]}}, instr_id_o[31:25], instr_id_o[11:7]};
            end
            OPC_BRANCH: begin
                imm_id_o = {{19{instr_id_o[31]}}, instr_id_o[31], instr_id_o[7],
                            instr_id_o[30:25], instr_id_o[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm_id_o = {instr_id_o[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm_id_o = {{11{instr_id_o[31]}}, instr_id_o[31], instr_id_o[19:12],
                            instr_id_o[20], instr_id_o[30:21], 1'b0};
            end
            default: begin
                imm_id_o = {{20{instr_id_o[31]}}, instr_id_o[31:20]};
            end
        endcase
    end

    // JAL resolves here
    assign jump_target_id_o = pc_id_o + imm_id_o;

    // Control flow class
    always_comb begin
        case (opcode)
            OPC_JAL:    pc_source_id_o = PC_JAL;
            OPC_JALR:   pc_source_id_o = PC_JALR;
            OPC_BRANCH: pc_source_id_o = PC_BRANCH;
            default:    pc_source_id_o = PC_PLUS4;
        endcase
    end

    // Operand read, rs1 and rs2 fields
    reg_file reg_file_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (instr_id_o[19:15]),
        .raddr2_i (instr_id_o[24:20]),
        .rdata1_o (rs1_val_id_o),
        .rdata2_o (rs2_val_id_o),
        .we_i     (rf_we_i),
        .waddr_i  (rf_waddr_i),
        .wdata_i  (rf_wdata_i)
    );

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Asynchronous read ports
    input  logic [RF_ADDR_W-1:0] raddr1_i,
    input  logic [RF_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]      rdata1_o,
    output logic [XLEN-1:0]      rdata2_o,

    // Write port
    input  logic                 we_i,
    input  logic [RF_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]      wdata_i
);

    // No storage behind x0
    logic [XLEN-1:0] regs [1:RF_DEPTH-1];

    // Architectural state of x1 to x31
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads see the value before a same cycle write
    // Register 0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== hdl/if_stage.sv ====
`timescale 1ns/1ps

module if_stage import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Instruction memory, answers in the same cycle
    input  logic [ILEN-1:0] imem_rdata_i,
    output logic [XLEN-1:0] imem_addr_o,

    // Towards ID
    output logic [XLEN-1:0] pc_if_o,
    output logic [ILEN-1:0] instr_if_o,
    output logic            valid_if_o,

    // Pipeline control
    input  logic            stall_if_i,
    input  logic            flush_id_i,

    // Redirect claims for the PC controller
    input  logic            valid_id_i,
    input  logic            valid_ex_i,
    input  logic [XLEN-1:0] jump_target_id_i,
    input  logic [XLEN-1:0] branch_target_ex_i,
    input  logic [XLEN-1:0] jalr_target_ex_i,
    input  logic            branch_decision_ex_i,
    input  pc_source_t      pc_source_id_i,
    input  pc_source_t      pc_source_ex_i
);

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    logic [XLEN-1:0] next_pc;

    // Fetch address straight from PC register
    assign imem_addr_o = pc_if_o;
    // Fetched word goes on to ID unchanged
    assign instr_if_o = imem_rdata_i;

    // PC register, held on stall
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_if_o <= RESET_PC;
        end else if (!stall_if_i) begin
            pc_if_o <= next_pc;
        end
    end

    // Next PC selection
    pc_controller pc_controller_i (
        .curr_pc_i            (pc_if_o),
        .jump_target_id_i     (jump_target_id_i),
        .branch_target_ex_i   (branch_target_ex_i),
        .jalr_target_ex_i     (jalr_target_ex_i),
        .valid_id_i           (valid_id_i),
        .valid_ex_i           (valid_ex_i),
        .branch_decision_ex_i (branch_decision_ex_i),
        .pc_source_id_i       (pc_source_id_i),
        .pc_source_ex_i       (pc_source_ex_i),
        .next_pc_o            (next_pc)
    );

    // Bubble when held or on the wrong path
    assign valid_if_o = !stall_if_i && !flush_id_i;

endmodule

// ==== hdl/pc_controller.sv ====
`timescale 1ns/1ps

module pc_controller import core_pkg::*; (
    // Current fetch address
    input  logic [XLEN-1:0] curr_pc_i,

    // Candidate targets
    input  logic [XLEN-1:0] jump_target_id_i,
    input  logic [XLEN-1:0] branch_target_ex_i,
    input  logic [XLEN-1:0] jalr_target_ex_i,

    // Stage claims
    input  logic            valid_id_i,
    input  logic            valid_ex_i,
    input  logic            branch_decision_ex_i,
    input  pc_source_t      pc_source_id_i,
    input  pc_source_t      pc_source_ex_i,

    output logic [XLEN-1:0] next_pc_o
);

    logic take_branch_ex;
    logic take_jalr_ex;
    logic take_jal_id;

    // EX claims, oldest instruction wins
    assign take_branch_ex = valid_ex_i && (pc_source_ex_i == PC_BRANCH) && branch_decision_ex_i;
    assign take_jalr_ex = valid_ex_i && (pc_source_ex_i == PC_JALR);
    // ID only redirects for JAL
    assign take_jal_id = valid_id_i && (pc_source_id_i == PC_JAL);

    // Priority select
    always_comb begin
        if (take_branch_ex) begin
            next_pc_o = branch_target_ex_i;
        end else if (take_jalr_ex) begin
            next_pc_o = jalr_target_ex_i;
        end else if (take_jal_id) begin
            next_pc_o = jump_target_id_i;
        end else begin
            next_pc_o = curr_pc_i + XLEN'(4);
        end
    end

endmodule

// ==== common/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Data and address width
    localparam int XLEN = 32;
    // Instruction word width
    localparam int ILEN = 32;
    // Register file geometry
    localparam int RF_ADDR_W = 5;
    localparam int RF_DEPTH = 32;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    // Control flow
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    // Non control flow formats that need their own immediate
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    // Branch funct3 encodings
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ADDI x0, x0, 0
    localparam logic [ILEN-1:0] NOP_INSTR = 32'h0000_0013;

    ////////////////////////////////////////
    // PC source
    ////////////////////////////////////////

    // Target that a stage claims for the next PC
    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_JAL    = 2'b01,
        PC_BRANCH = 2'b10,
        PC_JALR   = 2'b11
    } pc_source_t;

endpackage
